// ==== arm_pkg.sv ====
// ARM datapath shared types
`default_nettype none

package arm_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 4;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } nzcv_t;

    typedef enum logic [2:0] {
        ALU_MOV, ALU_MVN, ALU_ADD, ALU_SUB,
        ALU_AND, ALU_ORR, ALU_EOR
    } alu_op_e;

    typedef struct packed {
        logic        valid;
        logic [3:0]  cond;
        alu_op_e     alu_op;
        logic        wb_en;
        logic        set_flags;
        logic        mem_rd;
        logic        mem_wr;
        logic        use_imm;     // operand 2 is the rotated imm8
        logic [11:0] imm12;
        reg_addr_t   rd;
        reg_addr_t   rn;
        reg_addr_t   rs2;         // rm, or rd for a store
    } ctrl_t;

    typedef struct packed {
        logic      valid;
        logic      wb_en;
        logic      mem_rd;
        logic      mem_wr;
        reg_addr_t rd;
        word_t     result;        // alu result or memory address
        word_t     store_data;
    } ex_mem_t;

    typedef struct packed {
        logic      wb_valid;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

    function automatic logic cond_passed(input logic [3:0] cond, input nzcv_t f);
        case (cond)
            4'b0000: return f.z;                        // eq
            4'b0001: return !f.z;                       // ne
            4'b0010: return f.c;                        // cs
            4'b0011: return !f.c;                       // cc
            4'b0100: return f.n;                        // mi
            4'b0101: return !f.n;                       // pl
            4'b0110: return f.v;                        // vs
            4'b0111: return !f.v;                       // vc
            4'b1000: return f.c && !f.z;                // hi
            4'b1001: return !f.c || f.z;                // ls
            4'b1010: return f.n == f.v;                 // ge
            4'b1011: return f.n != f.v;                 // lt
            4'b1100: return !f.z && (f.n == f.v);       // gt
            4'b1101: return f.z || (f.n != f.v);        // le
            4'b1110: return 1'b1;                       // al
            default: return 1'b0;                       // 1111 never executes
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== arm_decoder.sv ====
// Instruction decoder
`timescale 1ns/100ps
`default_nettype none

module arm_decoder (
    input  logic               i_ins_valid,
    input  arm_pkg::word_t     i_ins,
    output arm_pkg::ctrl_t     o_ctrl,
    output arm_pkg::reg_addr_t o_rn_addr,
    output arm_pkg::reg_addr_t o_rs2_addr
);
    import arm_pkg::*;

    logic [1:0] ins_type;
    logic [3:0] opcode;
    logic       s_bit;                  // S for data ops, L for memory ops
    logic       is_test;
    logic       dp_known;
    alu_op_e    dp_op;

    assign ins_type = i_ins[27:26];
    assign opcode   = i_ins[24:21];
    assign s_bit    = i_ins[20];
    assign is_test  = (opcode == 4'b1010) || (opcode == 4'b1000);   // cmp, tst

    always_comb begin
        dp_known = 1'b1;
        case (opcode)
            4'b1101: dp_op = ALU_MOV;
            4'b1111: dp_op = ALU_MVN;
            4'b0100: dp_op = ALU_ADD;
            4'b0010: dp_op = ALU_SUB;
            4'b1010: dp_op = ALU_SUB;   // cmp
            4'b0000: dp_op = ALU_AND;
            4'b1000: dp_op = ALU_AND;   // tst
            4'b1100: dp_op = ALU_ORR;
            4'b0001: dp_op = ALU_EOR;
            default: begin
                dp_op    = ALU_MOV;
                dp_known = 1'b0;        // unsupported opcode becomes a no-op
            end
        endcase
    end

    always_comb begin
        o_ctrl       = '0;
        o_ctrl.valid = i_ins_valid;
        o_ctrl.cond  = i_ins[31:28];
        o_ctrl.imm12 = i_ins[11:0];
        o_ctrl.rd    = i_ins[15:12];
        o_ctrl.rn    = i_ins[19:16];
        o_ctrl.rs2   = i_ins[3:0];
        if (ins_type == 2'b00 && dp_known) begin
            o_ctrl.alu_op    = dp_op;
            o_ctrl.use_imm   = i_ins[25];
            o_ctrl.wb_en     = !is_test;
            o_ctrl.set_flags = s_bit || is_test;
        end else if (ins_type == 2'b01) begin
            o_ctrl.alu_op = ALU_ADD;
            o_ctrl.mem_rd = s_bit;
            o_ctrl.mem_wr = !s_bit;
            o_ctrl.wb_en  = s_bit;      // only ldr writes back
            if (!s_bit) begin
                o_ctrl.rs2 = i_ins[15:12];  // str reads its data from rd
            end
        end
    end

    assign o_rn_addr  = o_ctrl.rn;
    assign o_rs2_addr = o_ctrl.rs2;

    always_comb begin
        if (i_ins_valid) begin
            assert (!$isunknown(i_ins))
                else $error("instruction word unknown while valid");
        end
    end

endmodule

`default_nettype wire

// ==== arm_register_bank.sv ====
// General register bank
`timescale 1ns/100ps
`default_nettype none

module arm_register_bank (
    input  logic               clk,
    input  logic               i_reset_n,
    input  arm_pkg::reg_addr_t i_rd_addr_a,
    input  arm_pkg::reg_addr_t i_rd_addr_b,
    input  arm_pkg::wb_t       i_wb,
    output arm_pkg::word_t     o_rd_data_a,
    output arm_pkg::word_t     o_rd_data_b
);
    import arm_pkg::*;

    word_t regs [2**REG_ADDR_W];

    always_ff @(posedge clk or posedge i_reset_n) begin
        if (i_reset_n) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.wb_valid) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    // write-through, a read in the write cycle sees the new value
    assign o_rd_data_a = (i_wb.wb_valid && i_wb.rd == i_rd_addr_a) ? i_wb.data
                                                                    : regs[i_rd_addr_a];
    assign o_rd_data_b = (i_wb.wb_valid && i_wb.rd == i_rd_addr_b) ? i_wb.data
                                                                    : regs[i_rd_addr_b];

    a_wb_index_known: assert property (@(posedge clk) disable iff (i_reset_n)
        i_wb.wb_valid |-> !$isunknown(i_wb.rd))
        else $error("register write with unknown index");

endmodule

`default_nettype wire

// ==== arm_alu.sv ====
// Integer ALU with flag logic
`timescale 1ns/100ps
`default_nettype none

module arm_alu (
    input  arm_pkg::alu_op_e i_op,
    input  logic             i_use_imm,
    input  logic [11:0]      i_imm12,
    input  arm_pkg::word_t   i_a,
    input  arm_pkg::word_t   i_rm,
    input  arm_pkg::nzcv_t   i_flags,
    output arm_pkg::word_t   o_result,
    output arm_pkg::nzcv_t   o_flags
);
    import arm_pkg::*;

    logic [4:0]          rot_amt;
    logic [2*WORD_W-1:0] imm_pair;
    word_t               op2;
    logic [WORD_W:0]     sum;
    logic [WORD_W:0]     diff;

    assign rot_amt  = {i_imm12[11:8], 1'b0};        // rotate field counts bit pairs
    assign imm_pair = {2{{(WORD_W-8){1'b0}}, i_imm12[7:0]}};
    assign op2      = i_use_imm ? imm_pair[rot_amt +: WORD_W] : i_rm;   // ror via doubled word

    assign sum  = {1'b0, i_a} + {1'b0, op2};
    assign diff = {1'b0, i_a} + {1'b0, ~op2} + 1'b1;   // carry out means no borrow

    always_comb begin
        o_flags  = i_flags;             // c and v survive logic ops
        o_result = op2;
        case (i_op)
            ALU_MOV: o_result = op2;
            ALU_MVN: o_result = ~op2;
            ALU_ADD: begin
                o_result  = sum[WORD_W-1:0];
                o_flags.c = sum[WORD_W];
                o_flags.v = (i_a[WORD_W-1] == op2[WORD_W-1])
                         && (o_result[WORD_W-1] != i_a[WORD_W-1]);
            end
            ALU_SUB: begin
                o_result  = diff[WORD_W-1:0];
                o_flags.c = diff[WORD_W];
                o_flags.v = (i_a[WORD_W-1] != op2[WORD_W-1])
                         && (o_result[WORD_W-1] != i_a[WORD_W-1]);
            end
            ALU_AND: o_result = i_a & op2;
            ALU_ORR: o_result = i_a | op2;
            ALU_EOR: o_result = i_a ^ op2;
            default: o_result = op2;
        endcase
        o_flags.n = o_result[WORD_W-1];
        o_flags.z = (o_result == '0);
    end

endmodule

`default_nettype wire

// ==== arm_execute_stage.sv ====
// Execute stage with flag register
`timescale 1ns/100ps
`default_nettype none

module arm_execute_stage (
    input  logic             clk,
    input  logic             i_reset_n,
    input  arm_pkg::ctrl_t   i_ctrl,
    input  arm_pkg::word_t   i_rn_data,
    input  arm_pkg::word_t   i_rs2_data,
    output arm_pkg::ex_mem_t o_ex_mem,
    output arm_pkg::nzcv_t   o_nzcv
);
    import arm_pkg::*;

    ctrl_t ex_ctrl;
    word_t ex_rn;
    word_t ex_rs2;
    nzcv_t flags;
    word_t alu_result;
    nzcv_t alu_flags;
    word_t mem_addr;
    logic  cond_ok;
    logic  is_mem;

    always_ff @(posedge clk or posedge i_reset_n) begin
        if (i_reset_n) begin
            ex_ctrl <= '0;
        end else begin
            ex_ctrl <= i_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        ex_rn  <= i_rn_data;
        ex_rs2 <= i_rs2_data;
    end

    arm_alu u_alu (
        .i_op      (ex_ctrl.alu_op),
        .i_use_imm (ex_ctrl.use_imm),
        .i_imm12   (ex_ctrl.imm12),
        .i_a       (ex_rn),
        .i_rm      (ex_rs2),
        .i_flags   (flags),
        .o_result  (alu_result),
        .o_flags   (alu_flags)
    );

    assign cond_ok  = ex_ctrl.valid && cond_passed(ex_ctrl.cond, flags);
    assign is_mem   = ex_ctrl.mem_rd || ex_ctrl.mem_wr;
    assign mem_addr = ex_rn + {{(WORD_W-12){1'b0}}, ex_ctrl.imm12};   // zero-extended offset

    always_ff @(posedge clk or posedge i_reset_n) begin
        if (i_reset_n) begin
            flags    <= '0;
            o_ex_mem <= '0;
        end else begin
            if (cond_ok && ex_ctrl.set_flags) begin
                flags <= alu_flags;
            end
            o_ex_mem.valid      <= cond_ok;
            o_ex_mem.wb_en      <= cond_ok && ex_ctrl.wb_en;
            o_ex_mem.mem_rd     <= cond_ok && ex_ctrl.mem_rd;
            o_ex_mem.mem_wr     <= cond_ok && ex_ctrl.mem_wr;
            o_ex_mem.rd         <= ex_ctrl.rd;
            o_ex_mem.result     <= is_mem ? mem_addr : alu_result;
            o_ex_mem.store_data <= ex_rs2;
        end
    end

    assign o_nzcv = flags;

    a_mem_excl: assert property (@(posedge clk) disable iff (i_reset_n)
        !(o_ex_mem.mem_rd && o_ex_mem.mem_wr))
        else $error("load and store issued together");

endmodule

`default_nettype wire

// ==== arm_memory_stage.sv ====
// Data memory and write-back
`timescale 1ns/100ps
`default_nettype none

module arm_memory_stage #(
    parameter int DATA_DEPTH = 256
) (
    input  logic             clk,
    input  logic             i_reset_n,
    input  arm_pkg::ex_mem_t i_ex_mem,
    output arm_pkg::wb_t     o_wb
);
    import arm_pkg::*;

    localparam int IDX_W = $clog2(DATA_DEPTH);

    word_t            mem [DATA_DEPTH];
    logic [IDX_W-1:0] idx;
    word_t            ld_data;
    logic             wb_valid;
    logic             wb_load;
    reg_addr_t        wb_rd;
    word_t            wb_result;

    assign idx = i_ex_mem.result[IDX_W-1:0];   // word index, wraps at depth

    always_ff @(posedge clk) begin
        if (i_ex_mem.mem_wr) begin
            mem[idx] <= i_ex_mem.store_data;
        end else if (i_ex_mem.mem_rd) begin
            ld_data <= mem[idx];
        end
    end

    always_ff @(posedge clk or posedge i_reset_n) begin
        if (i_reset_n) begin
            wb_valid <= 1'b0;
            wb_load  <= 1'b0;
        end else begin
            wb_valid <= i_ex_mem.valid && i_ex_mem.wb_en;
            wb_load  <= i_ex_mem.mem_rd;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd     <= i_ex_mem.rd;
        wb_result <= i_ex_mem.result;
    end

    assign o_wb.wb_valid = wb_valid;
    assign o_wb.rd       = wb_rd;
    assign o_wb.data     = wb_load ? ld_data : wb_result;   // load data or carried result

    a_wb_rd_known: assert property (@(posedge clk) disable iff (i_reset_n)
        o_wb.wb_valid |-> !$isunknown(o_wb.rd))
        else $error("write-back with unknown destination");

endmodule

`default_nettype wire

// ==== arm_core.sv ====
// ARM integer core top level
`timescale 1ns/100ps
`default_nettype none

module arm_core #(
    parameter int DATA_DEPTH = 256
) (
    input  logic           clk,
    input  logic           i_reset_n,
    input  logic           i_ins_valid,
    input  arm_pkg::word_t i_ins,
    output arm_pkg::wb_t   o_wb,
    output arm_pkg::nzcv_t o_nzcv
);
    import arm_pkg::*;

    ctrl_t     ctrl;
    reg_addr_t rn_addr;
    reg_addr_t rs2_addr;
    word_t     rn_data;
    word_t     rs2_data;
    ex_mem_t   ex_mem;
    wb_t       wb;                      // also feeds the bank write port

    arm_decoder u_decoder (
        .i_ins_valid (i_ins_valid),
        .i_ins       (i_ins),
        .o_ctrl      (ctrl),
        .o_rn_addr   (rn_addr),
        .o_rs2_addr  (rs2_addr)
    );

    arm_register_bank u_regs (
        .clk         (clk),
        .i_reset_n   (i_reset_n),
        .i_rd_addr_a (rn_addr),
        .i_rd_addr_b (rs2_addr),
        .i_wb        (wb),
        .o_rd_data_a (rn_data),
        .o_rd_data_b (rs2_data)
    );

    arm_execute_stage u_execute (
        .clk         (clk),
        .i_reset_n   (i_reset_n),
        .i_ctrl      (ctrl),
        .i_rn_data   (rn_data),
        .i_rs2_data  (rs2_data),
        .o_ex_mem    (ex_mem),
        .o_nzcv      (o_nzcv)
    );

    arm_memory_stage #(
        .DATA_DEPTH  (DATA_DEPTH)
    ) u_memory (
        .clk         (clk),
        .i_reset_n   (i_reset_n),
        .i_ex_mem    (ex_mem),
        .o_wb        (wb)
    );

    assign o_wb = wb;

endmodule

`default_nettype wire

// ==== tb_arm_core.sv ====
// ARM core testbench
`timescale 1ns/100ps
`default_nettype none

module tb_arm_core;
    import arm_pkg::*;

    localparam int NAME_W    = 8 * 16;
    localparam int MAX_CASES = 64;
    localparam int DRAIN     = 20;

    typedef struct packed {
        logic [NAME_W-1:0] name;
        word_t             ins;
        int                idle;        // empty cycles after this instruction
        logic              exp_wb;
        reg_addr_t         rd;
        word_t             data;
        nzcv_t             nzcv;
    } case_t;

    typedef struct packed {
        logic [NAME_W-1:0] name;
        int                due;         // falling edge where the write-back shows
        wb_t               exp;
    } wb_exp_t;

    typedef struct packed {
        logic [NAME_W-1:0] name;
        int                due;
        nzcv_t             exp;
    } flag_exp_t;

    logic      clk;
    logic      i_reset_n;
    logic      i_ins_valid;
    word_t     i_ins;
    wb_t       o_wb;
    nzcv_t     o_nzcv;

    case_t     cases [MAX_CASES];
    int        num_cases;
    wb_exp_t   wb_q[$];
    flag_exp_t flag_q[$];
    int        fall_cnt;
    int        cycle_cnt = 0;
    int        cycle_limit = 0;
    int        pass_count;
    int        fail_count;

    arm_core #(
        .DATA_DEPTH  (256)
    ) DUT (
        .clk         (clk),
        .i_reset_n   (i_reset_n),
        .i_ins_valid (i_ins_valid),
        .i_ins       (i_ins),
        .o_wb        (o_wb),
        .o_nzcv      (o_nzcv)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d write-backs still pending",
                     cycle_cnt, wb_q.size());
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic note_failure(input string msg);
        $display("%s", msg);
        fail_count++;
    endtask

    task automatic check_wb(input logic [NAME_W-1:0] name, input wb_t exp, input wb_t act);
        if (act !== exp) begin
            $display("Mismatch %0s: expected r%0d=%h, got r%0d=%h",
                     name, exp.rd, exp.data, act.rd, act.data);
            fail_count++;
        end else begin
            $display("ok %0s: r%0d=%h", name, act.rd, act.data);
            pass_count++;
        end
    endtask

    task automatic check_flags(input logic [NAME_W-1:0] name, input nzcv_t exp,
                               input nzcv_t act);
        if (act !== exp) begin
            $display("Mismatch %0s: expected nzcv=%b, got nzcv=%b", name, exp, act);
            fail_count++;
        end else begin
            $display("ok %0s: nzcv=%b", name, act);
            pass_count++;
        end
    endtask

    task automatic load_cases();
        int                fd;
        int                n;
        string             line;
        logic [NAME_W-1:0] name;
        word_t             ins;
        int                idle;
        int                exp_wb;
        reg_addr_t         rd;
        word_t             data;
        logic [3:0]        flags;
        num_cases = 0;
        fd = $fopen("arm_cases.txt", "r");
        if (fd == 0) begin
            note_failure("cannot open arm_cases.txt");
            return;
        end
        while (!$feof(fd) && num_cases < MAX_CASES) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() < 2 || line.getc(0) == "#") continue;   // blank or comment
            name = '0;
            n = $sscanf(line, "%s %h %d %d %h %h %h", name, ins, idle, exp_wb, rd, data, flags);
            if (n != 7) begin
                note_failure({"unreadable case line: ", line});
                continue;
            end
            cases[num_cases].name   = name;
            cases[num_cases].ins    = ins;
            cases[num_cases].idle   = idle;
            cases[num_cases].exp_wb = (exp_wb != 0);
            cases[num_cases].rd     = rd;
            cases[num_cases].data   = data;
            cases[num_cases].nzcv   = flags;
            num_cases++;
        end
        $fclose(fd);
    endtask

    // one falling edge, then retire whatever results are due there
    task automatic step();
        wb_exp_t   w;
        flag_exp_t f;
        @(negedge clk);
        fall_cnt++;
        while (flag_q.size() > 0 && flag_q[0].due <= fall_cnt) begin
            f = flag_q.pop_front();
            check_flags(f.name, f.exp, o_nzcv);
        end
        if (o_wb.wb_valid) begin
            if (wb_q.size() == 0 || wb_q[0].due != fall_cnt) begin
                note_failure($sformatf("unexpected write-back to r%0d on edge %0d",
                                       o_wb.rd, fall_cnt));
            end else begin
                w = wb_q.pop_front();
                check_wb(w.name, w.exp, o_wb);
            end
        end else if (wb_q.size() > 0 && wb_q[0].due <= fall_cnt) begin
            w = wb_q.pop_front();
            note_failure($sformatf("no write-back seen for %0s", w.name));
        end
    endtask

    task automatic issue(input case_t c);
        wb_exp_t   w;
        flag_exp_t f;
        i_ins       = c.ins;
        i_ins_valid = 1'b1;
        if (c.exp_wb) begin
            w.name         = c.name;
            w.due          = fall_cnt + 3;  // wb register loads two edges after accept
            w.exp.wb_valid = 1'b1;
            w.exp.rd       = c.rd;
            w.exp.data     = c.data;
            wb_q.push_back(w);
        end
        f.name = c.name;
        f.due  = fall_cnt + 2;              // flag register loads one edge after accept
        f.exp  = c.nzcv;
        flag_q.push_back(f);
    endtask

    initial begin
        clk         = 1'b0;
        i_reset_n   = 1'b1;
        i_ins_valid = 1'b0;
        i_ins       = '0;
        fall_cnt    = 0;
        pass_count  = 0;
        fail_count  = 0;
        load_cases();
        cycle_limit = DRAIN;
        for (int i = 0; i < num_cases; i++) begin
            cycle_limit += 1 + cases[i].idle;
        end
        repeat (2) @(posedge clk);
        step();
        i_reset_n = 1'b0;
        for (int i = 0; i < num_cases; i++) begin
            step();
            issue(cases[i]);
            repeat (cases[i].idle) begin
                step();
                i_ins_valid = 1'b0;
            end
        end
        step();
        i_ins_valid = 1'b0;
        while (wb_q.size() > 0 || flag_q.size() > 0) begin
            step();
        end
        if (num_cases == 0) begin
            note_failure("no cases were run");
        end
        $display("%0d checks passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== arm_cases.txt ====
# name  instruction(hex)  idle_cycles  expect_wb  rd(hex)  data(hex)  nzcv(hex)
# nzcv is the flag register seen two falling edges after the instruction is driven
mov_r0      E3A0047F 0 1 0 7F000000 0
mov_r1      E3A01012 0 1 1 00000012 0
mov_r2      E3A024FF 0 1 2 FF000000 0
mvn_r3      E3E0300F 0 1 3 FFFFFFF0 0
mov_r4      E3A04034 2 1 4 00000034 0
add_r5      E0815004 0 1 5 00000046 0
sub_r6      E0446001 0 1 6 00000022 0
and_r7      E0027003 0 1 7 FF000000 0
orr_r8      E1818004 0 1 8 00000036 0
eor_r9      E0239001 0 1 9 FFFFFFE2 0
cmp_eq      E3510012 0 0 0 00000000 6
eq_taken    03A0A001 0 1 a 00000001 6
ne_skip     13A0A002 0 0 0 00000000 6
nv_skip     F3A0A003 0 0 0 00000000 6
cmp_lt      E1510004 0 0 0 00000000 8
gt_skip     C3A0B005 0 0 0 00000000 8
le_taken    D3A0B006 0 1 b 00000006 8
cmp_gt      E1540001 0 0 0 00000000 2
gt_taken    C3A0C007 0 1 c 00000007 2
adds_carry  E092D002 0 1 d FE000000 a
subs_zero   E055E005 0 1 e 00000000 6
adds_ovf    E090F000 0 1 f FE000000 9
ands_keep   E211A000 0 1 a 00000000 5
tst_neg     E31204FF 0 0 0 00000000 9
str_word    E5815010 0 0 0 00000000 9
ldr_word    E591B010 0 1 b 00000046 9
ldr_wrap    E591C110 2 1 c 00000046 9

// ==== tb.f ====
arm_pkg.sv
arm_decoder.sv
arm_register_bank.sv
arm_alu.sv
arm_execute_stage.sv
arm_memory_stage.sv
arm_core.sv
tb_arm_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_arm_core -f tb.f -o sim_arm_core
./obj_dir/sim_arm_core | tee sim.log

if grep -q "^>>> PASS$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
